/* hdl/core_pkg.sv */
// Mini core definitions: widths, opcode and FSM encodings, and the structs that link the stages.
package core_pkg;

	localparam int DATA_W    = 16;                // Datapath and register width.
	localparam int NUM_REGS  = 8;                 // Number of architectural registers.
	localparam int REG_AW    = 3;                 // Register index width.
	localparam int IMM_W     = 6;                 // Immediate field width in the instruction.
	localparam int ADDR_W    = 8;                 // APB word address width.
	localparam int MEM_WORDS = 64;                // SRAM depth, higher addresses fault.
	localparam int MEM_AW    = $clog2(MEM_WORDS); // SRAM row index width.
	localparam int TAG_W     = 8;                 // Trace sequence tag width.

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,                            // No register write.
		OP_LDI = 4'd1,                            // rd = sign-extended immediate.
		OP_ADD = 4'd2,                            // rd = rd + rs.
		OP_SUB = 4'd3,                            // rd = rd - rs.
		OP_AND = 4'd4,                            // rd = rd & rs.
		OP_XOR = 4'd5,                            // rd = rd ^ rs.
		OP_SHL = 4'd6,                            // rd = rs << imm[3:0].
		OP_LD  = 4'd7,                            // rd = mem[rs + imm].
		OP_ST  = 4'd8                             // mem[rs + imm] = rd.
	} op_e;

	typedef enum logic [1:0] {
		EX_IDLE,                                  // Waiting for an issue, ready is high.
		EX_ALU,                                   // Single cycle arithmetic.
		EX_SETUP,                                 // APB setup phase.
		EX_ACCESS                                 // APB access phase, held until pready.
	} exec_state_e;

	typedef struct packed {
		op_e               opcode;                // Bits 15:12.
		logic [REG_AW-1:0] rd;                    // Bits 11:9.
		logic [REG_AW-1:0] rs;                    // Bits 8:6.
		logic [IMM_W-1:0]  imm;                   // Bits 5:0, signed.
	} instr_t;

	typedef struct packed {
		logic              valid;                 // Issue strobe toward execute.
		op_e               op;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] src_val;               // Value of rs.
		logic [DATA_W-1:0] dst_val;               // Value of rd, also the store data.
		logic [DATA_W-1:0] imm;                   // Immediate after sign extension.
		instr_t            instr;
		logic [TAG_W-1:0]  tag;
	} issue_t;

	typedef struct packed {
		logic              valid;                 // High for exactly one cycle.
		logic              wr;                    // Architectural write of rd.
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] value;
		logic              err;                   // Copied from pslverr.
		instr_t            instr;
		logic [TAG_W-1:0]  tag;
	} result_t;

	typedef struct packed {
		logic              en;                    // Writes the register and frees its pending bit.
		logic [REG_AW-1:0] idx;
		logic [DATA_W-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic              valid;
		logic [TAG_W-1:0]  tag;
		instr_t            instr;
		logic              wr;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] value;                 // Zero when nothing is written.
		logic              err;
	} trace_t;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// Opcodes that retire with a write to rd.
	function automatic logic op_writes(input op_e op);
		return op inside {OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SHL, OP_LD};
	endfunction

endpackage

/* hdl/apb_sram.sv */
// APB slave SRAM with one wait state and an error response above its last word.
`timescale 1ns/1ps

module apb_sram import core_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  apb_req_t i_apb_req,
	output apb_rsp_t o_apb_rsp
);

	logic [DATA_W-1:0] mem [MEM_WORDS];          // Word storage.
	logic              wait_q;                   // Set in the first access cycle.
	logic              access;                   // Access phase of a transfer.
	logic              in_range;
	logic              ready;
	logic [MEM_AW-1:0] index;

	assign access   = i_apb_req.psel && i_apb_req.penable;
	assign in_range = (i_apb_req.paddr < ADDR_W'(MEM_WORDS));
	assign index    = i_apb_req.paddr[MEM_AW-1:0];
	assign ready    = access && wait_q;          // Second access cycle completes.

	always_comb begin
		o_apb_rsp.pready  = ready;
		o_apb_rsp.pslverr = ready && !in_range;  // Out-of-range words fault.
		o_apb_rsp.prdata  = in_range ? mem[index] : '0;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			wait_q <= 1'b0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;                     // Unwritten words read as zero.
			end
		end else begin
			wait_q <= access && !wait_q;          // Clears again on the ready cycle.
			if (ready && in_range && i_apb_req.pwrite) begin
				mem[index] <= i_apb_req.pwdata;
			end
		end
	end

endmodule

/* hdl/instr_decode.sv */
// Decode stage: one-entry instruction hold, register file, scoreboard and hazard-free issue.
`timescale 1ns/1ps

module instr_decode import core_pkg::*; (
	input  logic    clk,
	input  logic    i_reset,
	input  instr_t  i_instr,
	input  logic    i_instr_valid,
	output logic    o_instr_ready,
	input  logic    i_exec_ready,
	input  reg_wr_t i_reg_wr,
	output issue_t  o_issue
);

	instr_t              hold_q;                 // Instruction waiting for issue.
	logic                hold_valid;             // Hold register is occupied.
	logic [TAG_W-1:0]    hold_tag;               // Tag given at acceptance.
	logic [TAG_W-1:0]    next_tag;               // Tag for the next accepted instruction.
	logic [DATA_W-1:0]   regs [NUM_REGS];        // Architectural register file.
	logic [NUM_REGS-1:0] pending;                // One bit per register with a write in flight.
	logic [NUM_REGS-1:0] release_mask;           // Bit freed by this cycle's writeback.
	logic [NUM_REGS-1:0] set_mask;               // Bit claimed by this cycle's issue.
	logic [NUM_REGS-1:0] busy;                   // Pending bits after the release.
	logic                hazard;
	logic                issue_fire;
	logic                accept;
	logic                fwd_rs;                 // Writeback targets rs this cycle.
	logic                fwd_rd;                 // Writeback targets rd this cycle.

	assign release_mask  = i_reg_wr.en ? (NUM_REGS'(1) << i_reg_wr.idx) : '0;
	assign busy          = pending & ~release_mask;   // A same-cycle write counts as done.
	assign hazard        = busy[hold_q.rs] || busy[hold_q.rd];
	assign issue_fire    = hold_valid && i_exec_ready && !hazard;
	assign o_instr_ready = !hold_valid || issue_fire;   // Refill in the cycle the hold drains.
	assign accept        = i_instr_valid && o_instr_ready;

	// Only opcodes that write rd claim a scoreboard bit.
	assign set_mask = (issue_fire && op_writes(hold_q.opcode)) ? (NUM_REGS'(1) << hold_q.rd) : '0;

	assign fwd_rs = i_reg_wr.en && (i_reg_wr.idx == hold_q.rs);
	assign fwd_rd = i_reg_wr.en && (i_reg_wr.idx == hold_q.rd);

	always_comb begin
		o_issue.valid   = issue_fire;
		o_issue.op      = hold_q.opcode;
		o_issue.rd      = hold_q.rd;
		o_issue.src_val = fwd_rs ? i_reg_wr.data : regs[hold_q.rs];   // Bypass the register file.
		o_issue.dst_val = fwd_rd ? i_reg_wr.data : regs[hold_q.rd];
		o_issue.imm     = {{(DATA_W - IMM_W){hold_q.imm[IMM_W-1]}}, hold_q.imm};
		o_issue.instr   = hold_q;
		o_issue.tag     = hold_tag;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			hold_q   <= i_instr;                  // Payload only moves on a handshake.
			hold_tag <= next_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			hold_valid <= 1'b0;
			next_tag   <= '0;
			pending    <= '0;
		end else begin
			if (accept) begin
				hold_valid <= 1'b1;
				next_tag   <= next_tag + 1'b1;    // Tags follow acceptance order.
			end else if (issue_fire) begin
				hold_valid <= 1'b0;
			end
			pending <= busy | set_mask;           // Release first, so a reissue of rd keeps it set.
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_reg_wr.en) begin
			regs[i_reg_wr.idx] <= i_reg_wr.data;
		end
	end

endmodule

/* hdl/exec_unit.sv */
// Execute stage: one-cycle ALU and an APB master FSM for loads and stores.
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  issue_t   i_issue,
	output logic     o_exec_ready,
	output apb_req_t o_apb_req,
	input  apb_rsp_t i_apb_rsp,
	output result_t  o_result
);

	exec_state_e       state;
	issue_t            op_q;                     // Operation latched at issue.
	logic [DATA_W-1:0] alu_val;
	logic [DATA_W-1:0] addr_sum;                 // Full width rs + imm before truncation.
	logic              mem_op;                   // Incoming issue needs the bus.
	logic              done;                     // Execute finishes this cycle.
	result_t           res_next;
	result_t           result_q;
	logic              result_valid;

	assign o_exec_ready = (state == EX_IDLE);    // Decode only issues into an idle stage.
	assign mem_op       = (i_issue.op == OP_LD) || (i_issue.op == OP_ST);
	assign addr_sum     = op_q.src_val + op_q.imm;
	assign done         = (state == EX_ALU) || ((state == EX_ACCESS) && i_apb_rsp.pready);

	always_comb begin
		case (op_q.op)
			OP_LDI:  alu_val = op_q.imm;
			OP_ADD:  alu_val = op_q.dst_val + op_q.src_val;
			OP_SUB:  alu_val = op_q.dst_val - op_q.src_val;
			OP_AND:  alu_val = op_q.dst_val & op_q.src_val;
			OP_XOR:  alu_val = op_q.dst_val ^ op_q.src_val;
			OP_SHL:  alu_val = op_q.src_val << op_q.imm[3:0];   // Only four shift bits matter.
			default: alu_val = '0;                // NOP and unused codes.
		endcase
	end

	// Request fields come from the latched operation, so they hold steady while psel is up.
	always_comb begin
		o_apb_req.psel    = (state == EX_SETUP) || (state == EX_ACCESS);
		o_apb_req.penable = (state == EX_ACCESS);
		o_apb_req.pwrite  = (op_q.op == OP_ST);
		o_apb_req.paddr   = addr_sum[ADDR_W-1:0];
		o_apb_req.pwdata  = op_q.dst_val;
	end

	always_comb begin
		res_next.valid = 1'b1;
		res_next.rd    = op_q.rd;
		res_next.instr = op_q.instr;
		res_next.tag   = op_q.tag;
		res_next.err   = 1'b0;
		res_next.value = alu_val;
		if (state == EX_ACCESS) begin
			res_next.err = i_apb_rsp.pslverr;
			if (op_q.op == OP_LD && !i_apb_rsp.pslverr) begin
				res_next.value = i_apb_rsp.prdata;
			end else begin
				res_next.value = op_q.dst_val;   // Old rd, so a faulted load can free rd unchanged.
			end
		end
		res_next.wr = op_writes(op_q.op) && !res_next.err;   // A fault suppresses the write.
	end

	always_ff @(posedge clk) begin
		if ((state == EX_IDLE) && i_issue.valid) begin
			op_q <= i_issue;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			result_q <= res_next;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state        <= EX_IDLE;
			result_valid <= 1'b0;
		end else begin
			result_valid <= done;                 // One-cycle pulse per instruction.
			case (state)
				EX_IDLE: begin
					if (i_issue.valid) begin
						state <= mem_op ? EX_SETUP : EX_ALU;
					end
				end
				EX_ALU: begin
					state <= EX_IDLE;
				end
				EX_SETUP: begin
					state <= EX_ACCESS;           // Setup always lasts one cycle.
				end
				EX_ACCESS: begin
					if (i_apb_rsp.pready) begin
						state <= EX_IDLE;         // psel drops after the completing cycle.
					end
				end
				default: begin
					state <= EX_IDLE;
				end
			endcase
		end
	end

	always_comb begin
		o_result       = result_q;
		o_result.valid = result_valid;
	end

endmodule

/* hdl/result_stage.sv */
// Result stage: writes back registers, frees scoreboard bits and forms the trace record.
`timescale 1ns/1ps

module result_stage import core_pkg::*; (
	input  logic    clk,
	input  logic    i_reset,
	input  result_t i_result,
	output reg_wr_t o_reg_wr,
	output trace_t  o_trace
);

	logic   load_fault;                          // Load that got pslverr.
	trace_t trace_q;                             // Trace payload.
	logic   trace_valid;

	assign load_fault = i_result.err && (i_result.instr.opcode == OP_LD);

	// A faulted load rewrites the old rd value, which only releases the scoreboard bit.
	always_comb begin
		o_reg_wr.en   = i_result.valid && (i_result.wr || load_fault);
		o_reg_wr.idx  = i_result.rd;
		o_reg_wr.data = i_result.value;
	end

	always_ff @(posedge clk) begin
		if (i_result.valid) begin
			trace_q.valid <= 1'b1;
			trace_q.tag   <= i_result.tag;
			trace_q.instr <= i_result.instr;
			trace_q.wr    <= i_result.wr;
			trace_q.rd    <= i_result.rd;
			trace_q.value <= i_result.wr ? i_result.value : '0;   // Only written values show.
			trace_q.err   <= i_result.err;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			trace_valid <= 1'b0;
		end else begin
			trace_valid <= i_result.valid;      // One record per retired instruction.
		end
	end

	always_comb begin
		o_trace       = trace_q;
		o_trace.valid = trace_valid;
	end

endmodule

/* hdl/mini_core_top.sv */
// Mini core top: decode, execute and result stages with the APB SRAM on the data side.
`timescale 1ns/1ps

module mini_core_top import core_pkg::*; (
	input  logic   clk,
	input  logic   i_reset,
	input  instr_t i_instr,
	input  logic   i_instr_valid,
	output logic   o_instr_ready,
	output trace_t o_trace
);

	issue_t   issue;                             // Decode to execute.
	logic     exec_ready;                        // Execute is idle.
	result_t  result;                            // Execute to result.
	reg_wr_t  reg_wr;                            // Writeback and scoreboard release.
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	instr_decode u_decode (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_instr       (i_instr),
		.i_instr_valid (i_instr_valid),
		.o_instr_ready (o_instr_ready),
		.i_exec_ready  (exec_ready),
		.i_reg_wr      (reg_wr),
		.o_issue       (issue)
	);

	exec_unit u_exec (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_issue      (issue),
		.o_exec_ready (exec_ready),
		.o_apb_req    (apb_req),
		.i_apb_rsp    (apb_rsp),
		.o_result     (result)
	);

	result_stage u_result (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_result (result),
		.o_reg_wr (reg_wr),
		.o_trace  (o_trace)
	);

	// Single slave, so the bus goes straight to the SRAM.
	apb_sram u_sram (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_apb_req (apb_req),
		.o_apb_rsp (apb_rsp)
	);

endmodule

/* verif/mini_core_properties.sv */
// Bound assertions that check the APB master and issue completion in the execute stage.
`timescale 1ns/1ps

module mini_core_properties import core_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  issue_t   i_issue,
	input  apb_req_t o_apb_req,
	input  result_t  o_result
);

	// An access phase always follows exactly one setup cycle.
	property p_setup_before_enable;
		@(posedge clk) disable iff (i_reset)
			$rose(o_apb_req.penable) |-> $past(o_apb_req.psel && !o_apb_req.penable);
	endproperty

	// Address, direction and write data hold while the transfer is open.
	property p_request_stable;
		@(posedge clk) disable iff (i_reset)
			(o_apb_req.psel && $past(o_apb_req.psel)) |->
				$stable({o_apb_req.pwrite, o_apb_req.paddr, o_apb_req.pwdata});
	endproperty

	// Every issued operation leaves execute as a result pulse within four cycles.
	property p_issue_completes;
		@(posedge clk) disable iff (i_reset)
			i_issue.valid |-> ##[2:4] o_result.valid;
	endproperty

	a_setup_before_enable: assert property (p_setup_before_enable)
		else $error("penable rose without a preceding APB setup cycle.");
	a_request_stable: assert property (p_request_stable)
		else $error("APB request fields changed while psel was high.");
	a_issue_completes: assert property (p_issue_completes)
		else $error("An issued operation never produced an execute result.");

endmodule

bind exec_unit mini_core_properties u_props (
	.clk       (clk),
	.i_reset   (i_reset),
	.i_issue   (i_issue),
	.o_apb_req (o_apb_req),
	.o_result  (o_result)
);

/* verif/mini_core_tb.sv */
// Mini core testbench that drives an instruction table and checks every trace record against it.
`timescale 1ns/1ps

module mini_core_tb import core_pkg::*; ();

	typedef struct packed {
		instr_t            instr;                // Instruction sent to the core.
		logic              wr;                   // Expected trace write flag.
		logic [REG_AW-1:0] rd;                   // Expected destination field.
		logic [DATA_W-1:0] value;                // Expected written value, zero without a write.
		logic              err;                  // Expected bus error flag.
	} stim_t;

	logic   clk;
	logic   i_reset;
	instr_t i_instr;
	logic   i_instr_valid;
	logic   o_instr_ready;
	trace_t o_trace;

	stim_t  stim_q [$];                          // Stimulus and expected results in order.
	int     rec_count;                           // Trace records seen so far.
	int     err_count;                           // Failed checks.
	int     gap;                                 // Idle cycles after an instruction.

	mini_core_top UUT (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_instr       (i_instr),
		.i_instr_valid (i_instr_valid),
		.o_instr_ready (o_instr_ready),
		.o_trace       (o_trace)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;                   // 10 ns period.
	end

	function automatic instr_t make_instr(input op_e op, input int rd, input int rs, input int imm);
		instr_t ins;
		ins.opcode = op;
		ins.rd     = rd[REG_AW-1:0];
		ins.rs     = rs[REG_AW-1:0];
		ins.imm    = imm[IMM_W-1:0];             // Two's complement keeps negative values.
		return ins;
	endfunction

	task automatic add_entry(input op_e op, input int rd, input int rs, input int imm,
			input logic wr, input logic [DATA_W-1:0] value, input logic err);
		stim_t s;
		s.instr = make_instr(op, rd, rs, imm);
		s.wr    = wr;
		s.rd    = rd[REG_AW-1:0];
		s.value = value;
		s.err   = err;
		stim_q.push_back(s);
	endtask

	// Expected values follow the instruction semantics and are tracked by hand from zeroed registers.
	task automatic build_table();
		add_entry(OP_LDI, 1, 0, 5,   1'b1, 16'h0005, 1'b0);   // r1 = 5.
		add_entry(OP_LDI, 2, 0, -3,  1'b1, 16'hFFFD, 1'b0);   // Negative immediate.
		add_entry(OP_ADD, 1, 2, 0,   1'b1, 16'h0002, 1'b0);   // Depends on both loads.
		add_entry(OP_SUB, 2, 1, 0,   1'b1, 16'hFFFB, 1'b0);
		add_entry(OP_LDI, 3, 0, 12,  1'b1, 16'h000C, 1'b0);
		add_entry(OP_AND, 3, 2, 0,   1'b1, 16'h0008, 1'b0);
		add_entry(OP_XOR, 3, 1, 0,   1'b1, 16'h000A, 1'b0);
		add_entry(OP_SHL, 4, 3, 4,   1'b1, 16'h00A0, 1'b0);
		add_entry(OP_SHL, 5, 2, 31,  1'b1, 16'h8000, 1'b0);   // Shift by 15.
		add_entry(OP_SHL, 5, 1, -14, 1'b1, 16'h0008, 1'b0);   // Low four bits give 2.
		add_entry(OP_NOP, 0, 0, 0,   1'b0, 16'h0000, 1'b0);
		add_entry(OP_LDI, 6, 0, 20,  1'b1, 16'h0014, 1'b0);   // Base address 20.
		add_entry(OP_ST,  4, 6, 3,   1'b0, 16'h0000, 1'b0);   // mem[23] = 0x00A0.
		add_entry(OP_LD,  7, 6, 3,   1'b1, 16'h00A0, 1'b0);   // Reads the stored word back.
		add_entry(OP_LD,  0, 6, 10,  1'b1, 16'h0000, 1'b0);   // mem[30] was never written.
		add_entry(OP_ADD, 7, 7, 0,   1'b1, 16'h0140, 1'b0);
		add_entry(OP_ST,  7, 0, 0,   1'b0, 16'h0000, 1'b0);   // mem[0] = 0x0140.
		add_entry(OP_LD,  1, 0, 0,   1'b1, 16'h0140, 1'b0);
		add_entry(OP_LDI, 6, 0, 31,  1'b1, 16'h001F, 1'b0);
		add_entry(OP_ADD, 6, 6, 0,   1'b1, 16'h003E, 1'b0);
		add_entry(OP_ADD, 6, 3, 0,   1'b1, 16'h0048, 1'b0);   // r6 = 72, past the SRAM.
		add_entry(OP_LD,  2, 6, 0,   1'b0, 16'h0000, 1'b1);   // Faults and keeps old r2.
		add_entry(OP_ADD, 2, 1, 0,   1'b1, 16'h013B, 1'b0);   // Uses the unchanged r2.
		add_entry(OP_ST,  5, 6, -8,  1'b0, 16'h0000, 1'b1);   // Word 64 faults.
		add_entry(OP_LD,  3, 6, -9,  1'b1, 16'h0000, 1'b0);   // Word 63, the last one.
		add_entry(OP_ST,  2, 6, -9,  1'b0, 16'h0000, 1'b0);
		add_entry(OP_LD,  4, 6, -9,  1'b1, 16'h013B, 1'b0);
		add_entry(OP_SUB, 4, 5, 0,   1'b1, 16'h0133, 1'b0);
		add_entry(OP_XOR, 4, 2, 0,   1'b1, 16'h0008, 1'b0);
		add_entry(OP_LD,  0, 0, 0,   1'b1, 16'h0140, 1'b0);   // Base and destination are r0.
		add_entry(OP_ADD, 0, 0, 0,   1'b1, 16'h0280, 1'b0);
		add_entry(OP_LDI, 5, 0, -32, 1'b1, 16'hFFE0, 1'b0);   // Most negative immediate.
		add_entry(OP_LD,  7, 2, 0,   1'b1, 16'h0000, 1'b0);   // 0x013B wraps to word 59.
	endtask

	// Holds the instruction until the handshake completes at a rising edge.
	task automatic send_instr(input instr_t ins);
		i_instr       = ins;
		i_instr_valid = 1'b1;
		@(negedge clk);
		while (!o_instr_ready) begin
			@(negedge clk);                      // Ready is settled mid-cycle.
		end
		@(posedge clk);
		#1;
		i_instr_valid = 1'b0;
	endtask

	task automatic report_and_finish();
		$display("Trace records: %0d of %0d, error count: %0d", rec_count, stim_q.size(),
			err_count);
		if (err_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	initial begin
		i_reset       = 1'b1;
		i_instr       = '0;
		i_instr_valid = 1'b0;
		rec_count     = 0;
		err_count     = 0;
		void'($urandom(23456));                  // One fixed seed for the idle gaps.
		build_table();
		repeat (4) @(posedge clk);
		#1;
		i_reset = 1'b0;
		repeat (2) begin
			@(negedge clk);
			if (o_instr_ready !== 1'b1) begin
				$display("[ERROR] o_instr_ready after reset: expected 0x1, got 0x%h",
					o_instr_ready);
				err_count++;
			end
			if (o_trace.valid !== 1'b0) begin
				$display("[ERROR] o_trace.valid before the first instruction: expected 0x0, got 0x%h",
					o_trace.valid);
				err_count++;
			end
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < stim_q.size(); i++) begin
			send_instr(stim_q[i].instr);
			gap = (i < 16) ? 0 : $urandom_range(3, 0);   // First half runs back to back.
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
		wait (rec_count >= stim_q.size());
		repeat (10) @(posedge clk);              // Room for a stray extra record.
		report_and_finish();
	end

	// Compares each trace record with the table entry of the same index.
	initial begin
		forever begin
			@(negedge clk);
			if (!i_reset && o_trace.valid === 1'b1) begin
				if (rec_count >= stim_q.size()) begin
					$display("Extra trace record with tag 0x%h after the table ended",
						o_trace.tag);
					err_count++;
				end else begin
					if (o_trace.tag !== rec_count[TAG_W-1:0]) begin
						$display("[ERROR] o_trace.tag: expected 0x%h, got 0x%h",
							rec_count[TAG_W-1:0], o_trace.tag);
						err_count++;
					end
					if (o_trace.instr !== stim_q[rec_count].instr) begin
						$display("[ERROR] o_trace.instr: expected 0x%h, got 0x%h",
							stim_q[rec_count].instr, o_trace.instr);
						err_count++;
					end
					if (o_trace.wr !== stim_q[rec_count].wr) begin
						$display("[ERROR] o_trace.wr: expected 0x%h, got 0x%h",
							stim_q[rec_count].wr, o_trace.wr);
						err_count++;
					end
					if (o_trace.rd !== stim_q[rec_count].rd) begin
						$display("[ERROR] o_trace.rd: expected 0x%h, got 0x%h",
							stim_q[rec_count].rd, o_trace.rd);
						err_count++;
					end
					if (o_trace.value !== stim_q[rec_count].value) begin
						$display("[ERROR] o_trace.value: expected 0x%h, got 0x%h",
							stim_q[rec_count].value, o_trace.value);
						err_count++;
					end
					if (o_trace.err !== stim_q[rec_count].err) begin
						$display("[ERROR] o_trace.err: expected 0x%h, got 0x%h",
							stim_q[rec_count].err, o_trace.err);
						err_count++;
					end
				end
				rec_count++;
			end else if (rec_count == 0 && o_trace.valid === 1'b1) begin
				$display("Trace record appeared while reset was asserted");
				err_count++;
			end
		end
	end

	// Twenty cycles per table entry is far above the worst stall chain.
	initial begin
		wait (stim_q.size() > 0);
		repeat (stim_q.size() * 20 + 10) @(posedge clk);
		$display("Timeout: only %0d of %0d trace records arrived", rec_count, stim_q.size());
		err_count++;
		report_and_finish();
	end

endmodule

/* verilog.f */
hdl/core_pkg.sv
hdl/apb_sram.sv
hdl/instr_decode.sv
hdl/exec_unit.sv
hdl/result_stage.sv
hdl/mini_core_top.sv
verif/mini_core_properties.sv
verif/mini_core_tb.sv
